// File: verilog/up_macros.svh
`ifndef UP_MACROS_SVH
`define UP_MACROS_SVH

`define UP_DATA_W      8
`define UP_MEM_DEPTH   256
`define UP_NUM_REGS    8

`define UP_RESET_PC    8'h00
`define UP_INT_VECTOR  8'hF0
`define UP_STACK_TOP   8'hEF  // grows down

// datapath input select (rb_sel_in)
`define UP_SEL_MEM     3'd0
`define UP_SEL_ALU     3'd1
`define UP_SEL_OPR     3'd2
`define UP_SEL_SP_INC  3'd3
`define UP_SEL_SP_DEC  3'd4
`define UP_SEL_PC_INC  3'd5
`define UP_SEL_VEC     3'd6

// data_out select (addr_sel)
`define UP_ASEL_PC     2'd0
`define UP_ASEL_SP     2'd1
`define UP_ASEL_OPR    2'd2
`define UP_ASEL_RD     2'd3

`endif

// File: verilog/up_pkg.sv
`default_nettype none

`include "up_macros.svh"

package up_pkg;

   typedef logic [`UP_DATA_W-1:0] data_t;

   typedef enum logic [3:0] {
      OP_NOP  = 4'h0,
      OP_LDI  = 4'h1,
      OP_LD   = 4'h2,
      OP_ST   = 4'h3,
      OP_ADD  = 4'h4,
      OP_SUB  = 4'h5,
      OP_AND  = 4'h6,
      OP_XOR  = 4'h7,
      OP_INC  = 4'h8,
      OP_MOV  = 4'h9,
      OP_JMP  = 4'hA,
      OP_JZ   = 4'hB,
      OP_PUSH = 4'hC,
      OP_POP  = 4'hD,
      OP_OUT  = 4'hE,
      OP_SYS  = 4'hF
   } opcode_t;

   typedef enum logic [3:0] {
      FN_HLT  = 4'h0,
      FN_RETI = 4'h1
   } sys_fn_t;

   // low nibble is a register field or a system function, by opcode
   typedef union packed {
      struct packed {
         opcode_t    opcode;
         logic [2:0] rd;
         logic       spare;
      } r;
      struct packed {
         opcode_t opcode;
         sys_fn_t fn;
      } s;
   } instr_t;

   typedef enum logic [2:0] {
      ALU_PASS,
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_XOR,
      ALU_INC
   } alu_op_t;

   typedef enum logic [3:0] {
      S_IDLE,
      S_F0,
      S_F1,
      S_F2,
      S_DEC,
      S_OPW,
      S_OPX,
      S_SPA,
      S_MRD,
      S_MWB,
      S_PUSH,
      S_INT0,
      S_INT1,
      S_INT2,
      S_HALT
   } ctl_state_t;

endpackage

`default_nettype wire

// File: verilog/up_controller.sv
`timescale 1ns/10ps
`default_nettype none

`include "up_macros.svh"

module up_controller (
   input  wire logic           clk,
   input  wire logic           nRst,
   input  wire logic           run,
   input  wire logic           int_req,
   input  wire up_pkg::instr_t ir,
   input  wire logic           z,
   input  wire up_pkg::data_t  data_in,
   output up_pkg::alu_op_t     op,
   output logic                ir_we,
   output logic                pc_we,
   output logic                rb_we,
   output logic                sp_we,
   output logic                z_we,
   output logic [2:0]          rb_sel_in,
   output logic [1:0]          addr_sel,
   output logic                ale,
   output logic                mem_re,
   output logic                mem_we,
   output logic                port_we_req,
   output logic                halted
);
   import up_pkg::*;

   ctl_state_t state, state_nxt;
   logic       ie;
   instr_t     fetch_word;  // opcode byte arriving from memory in S_F2

   function automatic logic has_operand(input opcode_t opc);
      return opc inside {OP_LDI, OP_LD, OP_ST, OP_JMP, OP_JZ};
   endfunction

   function automatic alu_op_t alu_for(input opcode_t opc);
      case (opc)
         OP_ADD:  return ALU_ADD;
         OP_SUB:  return ALU_SUB;
         OP_AND:  return ALU_AND;
         OP_XOR:  return ALU_XOR;
         OP_INC:  return ALU_INC;
         default: return ALU_PASS;
      endcase
   endfunction

   assign fetch_word = data_in;

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         state <= S_IDLE;
         ie    <= 1'b1;
      end else begin
         state <= state_nxt;
         if (state == S_INT2)
            ie <= 1'b0;
         else if (state == S_MWB && ir.r.opcode == OP_SYS)
            ie <= 1'b1;  // reti
      end
   end

   always_comb begin
      op          = ALU_PASS;
      ir_we       = 1'b0;
      pc_we       = 1'b0;
      rb_we       = 1'b0;
      sp_we       = 1'b0;
      z_we        = 1'b0;
      rb_sel_in   = `UP_SEL_MEM;
      addr_sel    = `UP_ASEL_PC;
      ale         = 1'b0;
      mem_re      = 1'b0;
      mem_we      = 1'b0;
      port_we_req = 1'b0;
      halted      = 1'b0;
      state_nxt   = state;
      case (state)
         S_IDLE: if (run) state_nxt = S_F0;
         S_F0: begin
            if (int_req && ie) begin
               state_nxt = S_INT0;
            end else begin
               ale       = 1'b1;
               state_nxt = S_F1;
            end
         end
         S_F1: begin
            mem_re    = 1'b1;
            pc_we     = 1'b1;
            rb_sel_in = `UP_SEL_PC_INC;
            state_nxt = S_F2;
         end
         S_F2: begin
            ir_we     = 1'b1;
            ale       = has_operand(fetch_word.r.opcode);  // pc already points at operand
            state_nxt = S_DEC;
         end
         S_DEC: begin
            state_nxt = S_F0;
            case (ir.r.opcode)
               OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_INC: begin
                  op        = alu_for(ir.r.opcode);
                  rb_sel_in = `UP_SEL_ALU;
                  rb_we     = 1'b1;
                  z_we      = 1'b1;
               end
               OP_MOV: begin
                  rb_sel_in = `UP_SEL_ALU;  // pass r0 through
                  rb_we     = 1'b1;
               end
               OP_OUT: begin
                  addr_sel    = `UP_ASEL_RD;
                  port_we_req = 1'b1;
               end
               OP_LDI, OP_LD, OP_ST, OP_JMP, OP_JZ: begin
                  mem_re    = 1'b1;
                  pc_we     = 1'b1;
                  rb_sel_in = `UP_SEL_PC_INC;
                  state_nxt = S_OPW;
               end
               OP_PUSH: begin
                  ale       = 1'b1;
                  addr_sel  = `UP_ASEL_SP;
                  state_nxt = S_PUSH;
               end
               OP_POP: begin
                  sp_we     = 1'b1;
                  rb_sel_in = `UP_SEL_SP_INC;
                  state_nxt = S_SPA;
               end
               OP_SYS: begin
                  if (ir.s.fn == FN_HLT) begin
                     state_nxt = S_HALT;
                  end else if (ir.s.fn == FN_RETI) begin
                     sp_we     = 1'b1;
                     rb_sel_in = `UP_SEL_SP_INC;
                     state_nxt = S_SPA;
                  end
               end
               default: ;  // nop
            endcase
         end
         S_OPW: state_nxt = S_OPX;  // operand byte lands in opr
         S_OPX: begin
            state_nxt = S_F0;
            rb_sel_in = `UP_SEL_OPR;
            case (ir.r.opcode)
               OP_LDI: rb_we = 1'b1;
               OP_JMP: pc_we = 1'b1;
               OP_JZ:  pc_we = z;
               OP_LD, OP_ST: begin
                  ale       = 1'b1;
                  addr_sel  = `UP_ASEL_OPR;
                  state_nxt = S_MRD;
               end
               default: ;
            endcase
         end
         S_SPA: begin
            ale       = 1'b1;
            addr_sel  = `UP_ASEL_SP;
            state_nxt = S_MRD;
         end
         S_MRD: begin
            mem_re    = (ir.r.opcode != OP_ST);
            state_nxt = S_MWB;
         end
         S_MWB: begin
            state_nxt = S_F0;
            case (ir.r.opcode)
               OP_ST: begin
                  mem_we   = 1'b1;
                  addr_sel = `UP_ASEL_RD;
               end
               OP_SYS: pc_we = 1'b1;  // reti, pc from stack
               default: rb_we = 1'b1;  // ld, pop
            endcase
         end
         S_PUSH: begin
            mem_we    = 1'b1;
            addr_sel  = `UP_ASEL_RD;
            sp_we     = 1'b1;
            rb_sel_in = `UP_SEL_SP_DEC;
            state_nxt = S_F0;
         end
         S_INT0: begin
            ale       = 1'b1;
            addr_sel  = `UP_ASEL_SP;
            state_nxt = S_INT1;
         end
         S_INT1: begin
            mem_we    = 1'b1;  // save return pc
            sp_we     = 1'b1;
            rb_sel_in = `UP_SEL_SP_DEC;
            state_nxt = S_INT2;
         end
         S_INT2: begin
            pc_we     = 1'b1;
            rb_sel_in = `UP_SEL_VEC;
            state_nxt = S_F0;
         end
         S_HALT: begin
            halted = 1'b1;
            if (int_req && ie) state_nxt = S_INT0;
         end
         default: state_nxt = S_IDLE;
      endcase
   end

endmodule

`default_nettype wire

// File: verilog/up_datapath.sv
`timescale 1ns/10ps
`default_nettype none

`include "up_macros.svh"

module up_datapath (
   input  wire logic            clk,
   input  wire logic            nRst,
   input  wire up_pkg::data_t   data_in,
   input  wire up_pkg::alu_op_t op,
   input  wire logic            ir_we,
   input  wire logic            pc_we,
   input  wire logic            rb_we,
   input  wire logic            sp_we,
   input  wire logic            z_we,
   input  wire logic [2:0]      rb_sel_in,
   input  wire logic [1:0]      addr_sel,
   output up_pkg::data_t        data_out,
   output up_pkg::instr_t       ir,
   output logic                 z
);
   import up_pkg::*;

   data_t      regs [`UP_NUM_REGS];
   data_t      pc;
   data_t      sp;
   data_t      opr;      // last byte read from memory
   data_t      ra;
   data_t      rb;
   data_t      alu_y;
   data_t      din;
   logic [2:0] wr_idx;

   assign ra = regs[0];  // accumulator
   assign rb = regs[ir.r.rd];

   always_comb begin
      case (op)
         ALU_ADD: alu_y = ra + rb;
         ALU_SUB: alu_y = ra - rb;
         ALU_AND: alu_y = ra & rb;
         ALU_XOR: alu_y = ra ^ rb;
         ALU_INC: alu_y = rb + 1'b1;
         default: alu_y = ra;
      endcase
   end

   // two-operand ops land in r0, everything else in rd
   assign wr_idx = (op inside {ALU_ADD, ALU_SUB, ALU_AND, ALU_XOR}) ? 3'd0 : ir.r.rd;

   always_comb begin
      case (rb_sel_in)
         `UP_SEL_ALU:    din = alu_y;
         `UP_SEL_OPR:    din = opr;
         `UP_SEL_SP_INC: din = sp + 1'b1;
         `UP_SEL_SP_DEC: din = sp - 1'b1;
         `UP_SEL_PC_INC: din = pc + 1'b1;
         `UP_SEL_VEC:    din = `UP_INT_VECTOR;
         default:        din = data_in;
      endcase
   end

   always_comb begin
      case (addr_sel)
         `UP_ASEL_PC:  data_out = pc;
         `UP_ASEL_SP:  data_out = sp;
         `UP_ASEL_OPR: data_out = opr;
         default:      data_out = rb;
      endcase
   end

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         pc <= `UP_RESET_PC;
         sp <= `UP_STACK_TOP;
         z  <= 1'b0;
         ir <= '0;
      end else begin
         if (pc_we) pc <= din;
         if (sp_we) sp <= din;
         if (z_we)  z  <= (alu_y == '0);
         if (ir_we) ir <= data_in;
      end
   end

   always_ff @(posedge clk) begin
      opr <= data_in;
      if (rb_we) regs[wr_idx] <= din;
   end

endmodule

`default_nettype wire

// File: verilog/up_bus.sv
`timescale 1ns/10ps
`default_nettype none

module up_bus (
   input  wire logic          clk,
   input  wire logic          nRst,
   input  wire logic          run,
   input  wire logic          ale,
   input  wire logic          mem_we,
   input  wire logic          port_we_req,
   input  wire up_pkg::data_t data_out,
   input  wire logic          load_we,
   input  wire up_pkg::data_t load_addr,
   input  wire up_pkg::data_t load_data,
   output up_pkg::data_t      mem_addr,
   output up_pkg::data_t      mem_wdata,
   output logic               mem_wr,
   output up_pkg::data_t      port_data,
   output logic               port_we
);
   import up_pkg::*;

   data_t addr_latch;

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         addr_latch <= '0;
         port_data  <= '0;
         port_we    <= 1'b0;
      end else begin
         if (ale) addr_latch <= data_out;
         if (port_we_req) port_data <= data_out;
         port_we <= port_we_req;  // one-cycle pulse with the new data
      end
   end

   // loader owns memory while stopped
   assign mem_addr  = run ? addr_latch : load_addr;
   assign mem_wdata = run ? data_out : load_data;
   assign mem_wr    = run ? mem_we : load_we;

endmodule

`default_nettype wire

// File: verilog/up_memory.sv
`timescale 1ns/10ps
`default_nettype none

`include "up_macros.svh"

module up_memory (
   input  wire logic                  clk,
   input  wire logic [`UP_DATA_W-1:0] addr,
   input  wire logic [`UP_DATA_W-1:0] wdata,
   input  wire logic                  we,
   input  wire logic                  re,
   output logic      [`UP_DATA_W-1:0] rdata
);

   logic [`UP_DATA_W-1:0] mem [`UP_MEM_DEPTH];

   always_ff @(posedge clk) begin
      if (we) mem[addr] <= wdata;
      if (re) rdata <= we ? wdata : mem[addr];  // write-first
   end

endmodule

`default_nettype wire

// File: verilog/up.sv
`timescale 1ns/10ps
`default_nettype none

module up (
   input  wire logic          clk,
   input  wire logic          nRst,
   input  wire logic          run,
   input  wire logic          int_req,
   input  wire logic          load_we,
   input  wire up_pkg::data_t load_addr,
   input  wire up_pkg::data_t load_data,
   output up_pkg::data_t      port_data,
   output logic               port_we,
   output logic               halted
);
   import up_pkg::*;

   // controller strobes
   alu_op_t    op;
   logic       ir_we;
   logic       pc_we;
   logic       rb_we;
   logic       sp_we;
   logic       z_we;
   logic [2:0] rb_sel_in;
   logic [1:0] addr_sel;
   logic       ale;
   logic       mem_re;
   logic       mem_we;
   logic       port_we_req;

   // datapath and memory
   data_t      data_in;
   data_t      data_out;
   instr_t     ir;
   logic       z;
   data_t      mem_addr;
   data_t      mem_wdata;
   logic       mem_wr;

   up_controller up_controller_inst (
      .clk         (clk),
      .nRst        (nRst),
      .run         (run),
      .int_req     (int_req),
      .ir          (ir),
      .z           (z),
      .data_in     (data_in),
      .op          (op),
      .ir_we       (ir_we),
      .pc_we       (pc_we),
      .rb_we       (rb_we),
      .sp_we       (sp_we),
      .z_we        (z_we),
      .rb_sel_in   (rb_sel_in),
      .addr_sel    (addr_sel),
      .ale         (ale),
      .mem_re      (mem_re),
      .mem_we      (mem_we),
      .port_we_req (port_we_req),
      .halted      (halted)
   );

   up_datapath up_datapath_inst (
      .clk       (clk),
      .nRst      (nRst),
      .data_in   (data_in),
      .op        (op),
      .ir_we     (ir_we),
      .pc_we     (pc_we),
      .rb_we     (rb_we),
      .sp_we     (sp_we),
      .z_we      (z_we),
      .rb_sel_in (rb_sel_in),
      .addr_sel  (addr_sel),
      .data_out  (data_out),
      .ir        (ir),
      .z         (z)
   );

   up_bus up_bus_inst (
      .clk         (clk),
      .nRst        (nRst),
      .run         (run),
      .ale         (ale),
      .mem_we      (mem_we),
      .port_we_req (port_we_req),
      .data_out    (data_out),
      .load_we     (load_we),
      .load_addr   (load_addr),
      .load_data   (load_data),
      .mem_addr    (mem_addr),
      .mem_wdata   (mem_wdata),
      .mem_wr      (mem_wr),
      .port_data   (port_data),
      .port_we     (port_we)
   );

   up_memory up_memory_inst (
      .clk   (clk),
      .addr  (mem_addr),
      .wdata (mem_wdata),
      .we    (mem_wr),
      .re    (mem_re),
      .rdata (data_in)
   );

endmodule

`default_nettype wire

// File: sim/up_tb.sv
`timescale 1ns/10ps
`default_nettype none

module up_tb;
   import up_pkg::*;

   localparam string DATA_FILE = "sim/up_testdata.txt";

   logic       clk;
   logic       nRst;
   logic       run;
   logic       int_req;
   logic       load_we;
   data_t      load_addr;
   data_t      load_data;
   data_t      port_data;
   logic       port_we;
   logic       halted;

   data_t      ld_addr_q[$];
   data_t      ld_data_q[$];
   data_t      exp_q[$];
   int         int_pos = -1;  // index of the first value after the interrupt
   int         pass_cnt = 0;
   int         fail_cnt = 0;
   int         cycle_cnt = 0;
   int         cycle_limit = 0;
   int         pre_run_we = 0;
   int         pulse_cnt = 0;
   logic       pre_run_halt = 1'b0;
   ctl_state_t dbg_state;
   logic       data_ok;

   up up_inst (
      .clk       (clk),
      .nRst      (nRst),
      .run       (run),
      .int_req   (int_req),
      .load_we   (load_we),
      .load_addr (load_addr),
      .load_data (load_data),
      .port_data (port_data),
      .port_we   (port_we),
      .halted    (halted)
   );

   assign dbg_state = up_inst.up_controller_inst.state;

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
         $display("timeout after %0d cycles, controller in %s", cycle_cnt, dbg_state.name());
         $display("test failed");
         $finish;
      end
   end

   // nothing may reach the port before run, one pulse per OUT after
   always @(negedge clk) begin
      if (!run) begin
         if (port_we) pre_run_we++;
         if (halted) pre_run_halt = 1'b1;
      end else if (port_we) begin
         pulse_cnt++;
      end
   end

   task automatic check_port(input int idx, input data_t exp_val, input data_t act_val);
      if (act_val === exp_val) begin
         pass_cnt++;
         $display("port value %0d: 8'h%h ok", idx, act_val);
      end else begin
         fail_cnt++;
         $display("CHECK FAILED port_data value %0d expected 8'h%h got 8'h%h",
                  idx, exp_val, act_val);
      end
   endtask

   task automatic check_halt(input string where, input logic exp_val, input logic act_val);
      if (act_val === exp_val) begin
         pass_cnt++;
         $display("halted %s: %h ok", where, act_val);
      end else begin
         fail_cnt++;
         $display("CHECK FAILED halted %s expected %h got %h", where, exp_val, act_val);
      end
   endtask

   task automatic read_testdata(output logic ok);
      int              fd;
      int              n;
      logic [7:0]      tag;
      data_t           a;
      data_t           d;
      logic [8*80-1:0] rest;
      fd = $fopen(DATA_FILE, "r");
      ok = 1'b0;
      if (fd != 0) begin
         while (!$feof(fd)) begin
            n = $fscanf(fd, "%s", tag);
            if (n == 1) begin
               if (tag == "L") begin
                  n = $fscanf(fd, "%h %h", a, d);
                  ld_addr_q.push_back(a);
                  ld_data_q.push_back(d);
               end else if (tag == "E") begin
                  n = $fscanf(fd, "%h", d);
                  exp_q.push_back(d);
               end else if (tag == "I") begin
                  int_pos = exp_q.size();
               end else begin
                  n = $fgets(rest, fd);  // comment to end of line
               end
            end
         end
         $fclose(fd);
         ok = (ld_addr_q.size() > 0 && exp_q.size() > 0 && int_pos >= 0);
      end
   endtask

   task automatic load_memory();
      foreach (ld_addr_q[k]) begin
         @(posedge clk);
         #1;
         load_we   = 1'b1;
         load_addr = ld_addr_q[k];
         load_data = ld_data_q[k];
      end
      @(posedge clk);
      #1 load_we = 1'b0;
      $display("loaded %0d bytes", ld_addr_q.size());
   endtask

   task automatic wait_port(output data_t val);
      do begin
         @(negedge clk);
      end while (port_we !== 1'b1);
      val = port_data;
   endtask

   // waits for halt, then the port must stay quiet
   task automatic watch_halt(input string where);
      int pulses;
      pulses = 0;
      do begin
         @(negedge clk);
      end while (halted !== 1'b1);
      repeat (16) begin
         @(negedge clk);
         if (port_we) pulses++;
      end
      check_halt(where, 1'b1, halted);
      if (pulses == 0) begin
         pass_cnt++;
         $display("port quiet while halted %s ok", where);
      end else begin
         fail_cnt++;
         $display("port_we pulsed %0d times while halted %s", pulses, where);
      end
   endtask

   task automatic take_interrupt();
      @(posedge clk);
      #1 int_req = 1'b1;
      do begin
         @(negedge clk);
      end while (halted === 1'b1);
      @(posedge clk);
      #1 int_req = 1'b0;  // drop before reti turns ie back on
      $display("interrupt taken");
   endtask

   task automatic run_tests();
      data_t got;
      cycle_limit = ld_addr_q.size() + 64 * exp_q.size() + 200;
      repeat (3) @(posedge clk);
      #1 nRst = 1'b1;
      load_memory();
      if (pre_run_we == 0) begin
         pass_cnt++;
         $display("port quiet before run ok");
      end else begin
         fail_cnt++;
         $display("port_we pulsed %0d times before run", pre_run_we);
      end
      check_halt("before run", 1'b0, pre_run_halt);
      @(posedge clk);
      #1 run = 1'b1;
      for (int i = 0; i < exp_q.size(); i++) begin
         if (i == int_pos) begin
            watch_halt("after HLT");
            take_interrupt();
         end
         wait_port(got);
         check_port(i, exp_q[i], got);
      end
      watch_halt("at end of program");
      @(posedge clk);
      if (pulse_cnt == exp_q.size()) begin
         pass_cnt++;
         $display("port pulse count %0d ok", pulse_cnt);
      end else begin
         fail_cnt++;
         $display("port_we pulsed %0d times after run, expected %0d",
                  pulse_cnt, exp_q.size());
      end
   endtask

   task automatic finish_run();
      $display("checks passed %0d failed %0d", pass_cnt, fail_cnt);
      if (fail_cnt == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   endtask

   initial begin
      nRst      = 1'b0;
      run       = 1'b0;
      int_req   = 1'b0;
      load_we   = 1'b0;
      load_addr = '0;
      load_data = '0;
      read_testdata(data_ok);
      if (!data_ok) begin
         $display("could not read a complete program from %s", DATA_FILE);
         $display("test failed");
         $finish;
      end else begin
         run_tests();
         finish_run();
      end
   end

endmodule

`default_nettype wire

// File: sim/up_testdata.txt
# L addr byte loads one program byte, E value is the next expected port value
# I raises int_req once the DUT halts, before the values that follow it
L 00 10 # ldi r0 15
L 01 15
L 02 12 # ldi r1 07
L 03 07
L 04 42 # add r1
L 05 E0 # out r0
L 06 52 # sub r1
L 07 E0
L 08 14 # ldi r2 0f
L 09 0F
L 0A 64 # and r2
L 0B E0
L 0C 72 # xor r1
L 0D 80 # inc r0
L 0E 96 # mov r3
L 0F 86 # inc r3
L 10 E0
L 11 E6 # out r3
L 12 18 # ldi r4 a5
L 13 A5
L 14 38 # st r4 80
L 15 80
L 16 2A # ld r5 80
L 17 80
L 18 EA # out r5
L 19 C2 # push r1
L 1A DC # pop r6
L 1B EC # out r6
L 1C 10 # ldi r0 03
L 1D 03
L 1E 1E # ldi r7 00
L 1F 00
L 20 8E # inc r7
L 21 E0 # loop
L 22 5E # sub r7
L 23 B0 # jz 27
L 24 27
L 25 A0 # jmp 21
L 26 21
L 27 80 # inc r0 clears z
L 28 B0 # jz 2d not taken
L 29 2D
L 2A 14 # ldi r2 3c marker
L 2B 3C
L 2C E4
L 2D F0 # hlt
L 2E 10 # ldi r0 99 after reti
L 2F 99
L 30 E0
L 31 F0
L F0 12 # isr ldi r1 77
L F1 77
L F2 E2
L F3 F1 # reti
E 1C
E 15
E 05
E 03
E 04
E A5
E 07
E 03
E 02
E 01
E 3C
I
E 77
E 99

// File: sources.f
+incdir+verilog
verilog/up_pkg.sv
verilog/up_controller.sv
verilog/up_datapath.sv
verilog/up_bus.sv
verilog/up_memory.sv
verilog/up.sv
sim/up_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/10ps --top-module up_tb \
   -Mdir obj_dir -o up_sim -f sources.f

./obj_dir/up_sim | tee sim.log

if grep -qx "test failed" sim.log; then
   echo "simulation reported a failure"
   exit 1
fi
echo "simulation finished"
